/* verilog/lvda_pkg.sv */
package lvda_pkg;

    // processor data word, as seen on pio_rdata and on every source word.
    localparam int PIO_WORD_WIDTH = 26;

    // address map of the processor input/output port.
    localparam logic [8:0] ADDR_DIN_READ  = 9'h041;
    localparam logic [8:0] ADDR_INT_READ  = 9'h042;
    localparam logic [8:0] ADDR_INT_RESET = 9'h043;
    localparam logic [8:0] ADDR_DIN_REARM = 9'h044;

    // operation carried to a data source along with its strobe.
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_RESET = 1'b1
    } pio_op_e;

    // handshake states of the PIO controller.
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_STROBE    = 2'd1,
        ST_RESPOND   = 2'd2,
        ST_WAIT_DROP = 2'd3
    } pio_state_e;

endpackage

/* verilog/pio_src_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pio_src_if #(
    parameter int WORD_WIDTH = 26
);

    logic                  strobe;
    lvda_pkg::pio_op_e     op;
    logic [WORD_WIDTH-1:0] word;
    logic                  flag;

    modport ctrl (output strobe, output op, input word, input flag);

    modport src (input strobe, input op, output word, output flag);

endinterface

`default_nettype wire

/* verilog/input_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module input_filter #(
    parameter int WIDTH         = 1,
    parameter int FILTER_CYCLES = 3
) (
    input  logic             sim_clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] clean
);

    localparam int CNT_W = $clog2(FILTER_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FILTER_CYCLES - 1);

    logic [WIDTH-1:0] sync1;
    logic [WIDTH-1:0] sync2;

    // the lines are asynchronous to sim_clk, so bring them in through two flops.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
        end
    end

    for (genvar i = 0; i < WIDTH; i++) begin : g_line
        logic [CNT_W-1:0] cnt;
        logic             level;

        // count samples that disagree with the output; any agreeing sample
        // restarts the count, so a short transient never gets through.
        always_ff @(posedge sim_clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt   <= '0;
                level <= 1'b0;
            end else if (sync2[i] == level) begin
                cnt <= '0;
            end else if (cnt == CNT_LAST) begin
                cnt   <= '0;
                level <= sync2[i];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        assign clean[i] = level;
    end

endmodule

`default_nettype wire

/* verilog/discrete_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module discrete_sampler #(
    parameter int DIN_WIDTH = 24
) (
    input  logic                 sim_clk,
    input  logic                 rst_n,
    input  logic [DIN_WIDTH-1:0] din_clean,
    pio_src_if.src               bus
);

    logic [DIN_WIDTH-1:0] word_q;
    logic [DIN_WIDTH-1:0] ref_q;
    logic                 flag_q;

    always_ff @(posedge sim_clk) begin
        if (bus.strobe && bus.op == lvda_pkg::OP_READ) begin
            word_q <= din_clean;
        end
    end

    // both a read and a re-arm take the current discretes as the new reference.
    // the change flag is registered and follows one cycle behind.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_q  <= '0;
            flag_q <= 1'b0;
        end else begin
            if (bus.strobe) begin
                ref_q <= din_clean;
            end
            flag_q <= (din_clean != ref_q);
        end
    end

    assign bus.word = lvda_pkg::PIO_WORD_WIDTH'(word_q);
    assign bus.flag = flag_q;

endmodule

`default_nettype wire

/* verilog/interrupt_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_latch #(
    parameter int INTR_COUNT = 7
) (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  logic [INTR_COUNT-1:0] intr_clean,
    pio_src_if.src                bus
);

    logic [INTR_COUNT-1:0] prev_q;
    logic [INTR_COUNT-1:0] latched_q;
    logic [INTR_COUNT-1:0] word_q;
    logic [INTR_COUNT-1:0] rise;

    assign rise = intr_clean & ~prev_q;

    // a reset clears every latched bit, but an edge arriving in the
    // same cycle is kept so that no interrupt is lost.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_q    <= '0;
            latched_q <= '0;
        end else begin
            prev_q <= intr_clean;
            if (bus.strobe && bus.op == lvda_pkg::OP_RESET) begin
                latched_q <= rise;
            end else begin
                latched_q <= latched_q | rise;
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (bus.strobe && bus.op == lvda_pkg::OP_READ) begin
            word_q <= latched_q;
        end
    end

    assign bus.word = lvda_pkg::PIO_WORD_WIDTH'(word_q);
    assign bus.flag = |latched_q;

endmodule

`default_nettype wire

/* verilog/pio_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module pio_controller #(
    parameter int ADDR_WIDTH = 9
) (
    input  logic                                sim_clk,
    input  logic                                rst_n,
    input  logic                                pio_req,
    input  logic [ADDR_WIDTH-1:0]               pio_addr,
    input  logic                                pio_wr,
    output logic                                pio_ack,
    output logic [lvda_pkg::PIO_WORD_WIDTH-1:0] pio_rdata,
    pio_src_if.ctrl                             din_bus,
    pio_src_if.ctrl                             int_bus
);

    lvda_pkg::pio_state_e state;
    lvda_pkg::pio_op_e    op_q;
    logic                 req_q;
    logic                 sel_din;
    logic                 sel_int;
    logic                 hit_din;
    logic                 hit_int;
    logic                 reset_addr;

    // address decode. A reset address without wr is treated as a plain read.
    assign hit_din = (pio_addr == ADDR_WIDTH'(lvda_pkg::ADDR_DIN_READ)) ||
                     (pio_addr == ADDR_WIDTH'(lvda_pkg::ADDR_DIN_REARM));
    assign hit_int = (pio_addr == ADDR_WIDTH'(lvda_pkg::ADDR_INT_READ)) ||
                     (pio_addr == ADDR_WIDTH'(lvda_pkg::ADDR_INT_RESET));
    assign reset_addr = (pio_addr == ADDR_WIDTH'(lvda_pkg::ADDR_DIN_REARM)) ||
                        (pio_addr == ADDR_WIDTH'(lvda_pkg::ADDR_INT_RESET));

    // sample the request once, so every decision below sees the same value.
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= pio_req;
        end
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lvda_pkg::ST_IDLE;
            op_q      <= lvda_pkg::OP_READ;
            sel_din   <= 1'b0;
            sel_int   <= 1'b0;
            pio_ack   <= 1'b0;
            pio_rdata <= '0;
        end else begin
            case (state)
                lvda_pkg::ST_IDLE: begin
                    if (req_q) begin
                        sel_din <= hit_din;
                        sel_int <= hit_int;
                        op_q    <= (pio_wr && reset_addr) ? lvda_pkg::OP_RESET
                                                          : lvda_pkg::OP_READ;
                        state   <= lvda_pkg::ST_STROBE;
                    end
                end
                lvda_pkg::ST_STROBE: begin
                    state <= lvda_pkg::ST_RESPOND;
                end
                lvda_pkg::ST_RESPOND: begin
                    // the source has acted on its strobe by now, so its word is settled.
                    if (op_q == lvda_pkg::OP_READ && sel_din) begin
                        pio_rdata <= din_bus.word;
                    end else if (op_q == lvda_pkg::OP_READ && sel_int) begin
                        pio_rdata <= int_bus.word;
                    end else begin
                        pio_rdata <= '0;
                    end
                    pio_ack <= 1'b1;
                    state   <= lvda_pkg::ST_WAIT_DROP;
                end
                lvda_pkg::ST_WAIT_DROP: begin
                    if (!req_q) begin
                        pio_ack <= 1'b0;
                        state   <= lvda_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= lvda_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // strobes last exactly one cycle and only reach the addressed source.
    assign din_bus.strobe = (state == lvda_pkg::ST_STROBE) && sel_din;
    assign int_bus.strobe = (state == lvda_pkg::ST_STROBE) && sel_int;
    assign din_bus.op     = op_q;
    assign int_bus.op     = op_q;

endmodule

`default_nettype wire

/* verilog/lvda_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lvda_top #(
    parameter int DIN_WIDTH     = 24,
    parameter int INTR_COUNT    = 7,
    parameter int ADDR_WIDTH    = 9,
    parameter int FILTER_CYCLES = 3
) (
    input  logic                                sim_clk,
    input  logic                                rst_n,
    input  logic [DIN_WIDTH-1:0]                din,
    input  logic [INTR_COUNT-1:0]               intr,
    input  logic                                pio_req,
    input  logic [ADDR_WIDTH-1:0]               pio_addr,
    input  logic                                pio_wr,
    output logic                                pio_ack,
    output logic [lvda_pkg::PIO_WORD_WIDTH-1:0] pio_rdata,
    output logic                                intc,
    output logic                                dinf
);

    logic [DIN_WIDTH-1:0]  din_clean;
    logic [INTR_COUNT-1:0] intr_clean;

    pio_src_if #(.WORD_WIDTH(lvda_pkg::PIO_WORD_WIDTH)) din_bus ();
    pio_src_if #(.WORD_WIDTH(lvda_pkg::PIO_WORD_WIDTH)) int_bus ();

    input_filter #(
        .WIDTH         (DIN_WIDTH),
        .FILTER_CYCLES (FILTER_CYCLES)
    ) din_filt_i (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .raw     (din),
        .clean   (din_clean)
    );

    input_filter #(
        .WIDTH         (INTR_COUNT),
        .FILTER_CYCLES (FILTER_CYCLES)
    ) int_filt_i (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .raw     (intr),
        .clean   (intr_clean)
    );

    discrete_sampler #(
        .DIN_WIDTH (DIN_WIDTH)
    ) discrete_sampler_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .din_clean (din_clean),
        .bus       (din_bus)
    );

    interrupt_latch #(
        .INTR_COUNT (INTR_COUNT)
    ) interrupt_latch_i (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .intr_clean (intr_clean),
        .bus        (int_bus)
    );

    pio_controller #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) pio_controller_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .pio_req   (pio_req),
        .pio_addr  (pio_addr),
        .pio_wr    (pio_wr),
        .pio_ack   (pio_ack),
        .pio_rdata (pio_rdata),
        .din_bus   (din_bus),
        .int_bus   (int_bus)
    );

    // the source flags leave the adapter as the change and interrupt lines.
    assign dinf = din_bus.flag;
    assign intc = int_bus.flag;

endmodule

`default_nettype wire

/* bench/lvda_tb.sv */
`timescale 1ns/1ps

module lvda_tb;

    localparam int DIN_WIDTH       = 24;
    localparam int INTR_COUNT      = 7;
    localparam int ADDR_WIDTH      = 9;
    localparam int FILTER_CYCLES   = 3;
    localparam int WORD_WIDTH      = lvda_pkg::PIO_WORD_WIDTH;
    localparam int ACK_LIMIT       = 16;
    localparam int CYCLES_PER_LINE = 40;
    localparam string DATA_FILE    = "bench/lvda_testdata.txt";

    logic                  sim_clk = 1'b0;
    logic                  rst_n;
    logic [DIN_WIDTH-1:0]  din;
    logic [INTR_COUNT-1:0] intr;
    logic                  pio_req;
    logic [ADDR_WIDTH-1:0] pio_addr;
    logic                  pio_wr;
    logic                  pio_ack;
    logic [WORD_WIDTH-1:0] pio_rdata;
    logic                  intc;
    logic                  dinf;

    integer seed;
    int     line_count  = 0;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;
    int     pass_count  = 0;
    int     cur_test    = -1;
    int     test_errors = 0;

    always #2 sim_clk = ~sim_clk;

    lvda_top #(
        .DIN_WIDTH     (DIN_WIDTH),
        .INTR_COUNT    (INTR_COUNT),
        .ADDR_WIDTH    (ADDR_WIDTH),
        .FILTER_CYCLES (FILTER_CYCLES)
    ) lvda_top_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .din       (din),
        .intr      (intr),
        .pio_req   (pio_req),
        .pio_addr  (pio_addr),
        .pio_wr    (pio_wr),
        .pio_ack   (pio_ack),
        .pio_rdata (pio_rdata),
        .intc      (intc),
        .dinf      (dinf)
    );

    task automatic count_failure();
        error_count++;
        test_errors++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d: pass", cur_test);
        end else begin
            $display("test %0d: fail with %0d error(s)", cur_test, test_errors);
        end
    endtask

    task automatic start_test(input int id);
        if (cur_test >= 0) begin
            finish_test();
        end
        cur_test    = id;
        test_errors = 0;
        test_count++;
    endtask

    // ack is expected to be idle whenever the flags are looked at.
    task automatic check_flags(input logic intc_exp, input logic dinf_exp);
        @(negedge sim_clk);
        check_count += 3;
        if (pio_ack !== 1'b0) begin
            $display("[ERROR] %0d ns: pio_ack is high with no request pending", $time);
            count_failure();
        end
        if (intc !== intc_exp) begin
            $display("[ERROR] %0d ns: intc is %b, expected %b", $time, intc, intc_exp);
            count_failure();
        end
        if (dinf !== dinf_exp) begin
            $display("[ERROR] %0d ns: dinf is %b, expected %b", $time, dinf, dinf_exp);
            count_failure();
        end
    endtask

    // a pulse shorter than the filter window never reaches the sources, so the
    // matching flag must stay where it was until the filter has had time to react.
    task automatic pulse_line(input logic on_intr, input int idx, input int cycles);
        logic flag_before;
        @(negedge sim_clk);
        flag_before = on_intr ? intc : dinf;
        @(posedge sim_clk);
        if (on_intr) begin
            intr[idx] <= ~intr[idx];
        end else begin
            din[idx] <= ~din[idx];
        end
        repeat (cycles) @(posedge sim_clk);
        if (on_intr) begin
            intr[idx] <= ~intr[idx];
        end else begin
            din[idx] <= ~din[idx];
        end
        if (cycles < FILTER_CYCLES) begin
            repeat (FILTER_CYCLES + 4) begin
                @(negedge sim_clk);
                check_count++;
                if ((on_intr ? intc : dinf) !== flag_before) begin
                    $display("[ERROR] %0d ns: %s moved after a %0d-cycle pulse on line %0d",
                             $time, on_intr ? "intc" : "dinf", cycles, idx);
                    count_failure();
                end
            end
        end
    endtask

    // one full four-phase transfer. The request is held for hold extra cycles
    // after the acknowledge, and ack and rdata must not move meanwhile.
    task automatic bus_access(input logic [ADDR_WIDTH-1:0] addr, input logic wr,
                              input int hold, input logic [WORD_WIDTH-1:0] expected);
        int edges;
        edges = 0;
        @(posedge sim_clk);
        pio_addr <= addr;
        pio_wr   <= wr;
        pio_req  <= 1'b1;
        do begin
            @(posedge sim_clk);
            edges++;
            @(negedge sim_clk);
        end while (!pio_ack && edges < ACK_LIMIT);
        check_count += 2;
        if (!pio_ack) begin
            $display("no acknowledge for address 0x%h within %0d cycles", addr, ACK_LIMIT);
            count_failure();
        end else begin
            // the request is sampled on the first edge after it is driven.
            if (edges - 1 != 3) begin
                $display("[ERROR] %0d ns: ack rose %0d edges after req was sampled, expected 3",
                         $time, edges - 1);
                count_failure();
            end
            if (pio_rdata !== expected) begin
                $display("[ERROR] %0d ns: address 0x%h read 0x%h, expected 0x%h",
                         $time, addr, pio_rdata, expected);
                count_failure();
            end
            repeat (hold) begin
                @(negedge sim_clk);
                check_count++;
                if (pio_ack !== 1'b1 || pio_rdata !== expected) begin
                    $display("[ERROR] %0d ns: ack %b rdata 0x%h moved while req was held",
                             $time, pio_ack, pio_rdata);
                    count_failure();
                end
            end
        end
        @(posedge sim_clk);
        pio_req <= 1'b0;
        edges = 0;
        do begin
            @(posedge sim_clk);
            edges++;
            @(negedge sim_clk);
        end while (pio_ack && edges < ACK_LIMIT);
        check_count++;
        if (pio_ack) begin
            $display("pio_ack stayed high after the request for 0x%h was dropped", addr);
            count_failure();
        end else if (edges - 1 != 1) begin
            $display("[ERROR] %0d ns: ack fell %0d edges after req was sampled low, expected 1",
                     $time, edges - 1);
            count_failure();
        end
    endtask

    // a read returns the filtered discretes, so the pattern comes back as it is.
    task automatic random_read();
        integer              rnd;
        logic [DIN_WIDTH-1:0] pattern;
        rnd     = $random(seed);
        pattern = rnd[DIN_WIDTH-1:0];
        @(posedge sim_clk);
        din <= pattern;
        repeat (FILTER_CYCLES + 4) @(posedge sim_clk);
        bus_access(lvda_pkg::ADDR_DIN_READ, 1'b0, 0, WORD_WIDTH'(pattern));
    endtask

    initial begin
        wait (line_count > 0);
        repeat (line_count * CYCLES_PER_LINE) @(posedge sim_clk);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 line_count * CYCLES_PER_LINE);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int                 fd;
        int                 code;
        logic [7:0]         cmd;
        logic [8*128-1:0]   line;
        logic [31:0]        arg0;
        logic [31:0]        arg1;
        logic [31:0]        arg2;
        logic [31:0]        arg3;
        logic               at_end;
        rst_n    = 1'b0;
        din      = '0;
        intr     = '0;
        pio_req  = 1'b0;
        pio_addr = '0;
        pio_wr   = 1'b0;
        seed     = 32'he17e_fa28;
        at_end   = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", DATA_FILE);
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    line_count++;
                end
            end
            $fclose(fd);
            fd = $fopen(DATA_FILE, "r");
        end
        repeat (2) @(posedge sim_clk);
        rst_n <= 1'b1;
        while (fd != 0 && !at_end) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                at_end = 1'b1;
            end else begin
                case (cmd)
                    "#": begin
                        code = $fgets(line, fd);
                    end
                    "t": begin
                        code = $fscanf(fd, " %d", arg0);
                        start_test(int'(arg0));
                    end
                    "d": begin
                        code = $fscanf(fd, " %h", arg0);
                        @(posedge sim_clk);
                        din <= arg0[DIN_WIDTH-1:0];
                    end
                    "i": begin
                        code = $fscanf(fd, " %h", arg0);
                        @(posedge sim_clk);
                        intr <= arg0[INTR_COUNT-1:0];
                    end
                    "p", "q": begin
                        code = $fscanf(fd, " %d %d", arg0, arg1);
                        pulse_line(cmd == "q", int'(arg0), int'(arg1));
                    end
                    "w": begin
                        code = $fscanf(fd, " %d", arg0);
                        repeat (arg0) @(posedge sim_clk);
                    end
                    "b": begin
                        code = $fscanf(fd, " %h %h %d %h", arg0, arg1, arg2, arg3);
                        bus_access(arg0[ADDR_WIDTH-1:0], arg1[0], int'(arg2),
                                   arg3[WORD_WIDTH-1:0]);
                    end
                    "f": begin
                        code = $fscanf(fd, " %h %h", arg0, arg1);
                        check_flags(arg0[0], arg1[0]);
                    end
                    "r": begin
                        random_read();
                    end
                    default: begin
                        $display("unknown command '%c' in %s, stimulus stopped", cmd, DATA_FILE);
                        error_count++;
                        at_end = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (cur_test >= 0) begin
            finish_test();
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 test_count, pass_count, test_count - pass_count, check_count, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* bench/lvda_testdata.txt */
# t id | d din(hex) | i intr(hex) | p din line, q intr line: line cycles (dec)
# w cycles (dec) | b addr wr hold(dec) rdata (hex) | f intc dinf | r random discrete read
t 1
f 0 0
d a5c3f0
w 8
f 0 1
b 041 0 0 a5c3f0
f 0 0
t 2
d a5c3f1
w 8
f 0 1
b 044 1 0 0
f 0 0
b 041 0 0 a5c3f1
t 3
p 4 1
q 3 1
w 8
f 0 0
b 041 0 0 a5c3f1
b 042 0 0 0
t 4
i 25
w 8
f 1 0
b 042 0 0 25
b 043 1 0 0
f 0 0
b 042 0 0 0
i 65
w 8
f 1 0
b 042 0 0 40
t 5
b 1ff 0 3 0
b 000 1 0 0
f 1 0
b 043 1 0 0
f 0 0
t 6
r
f 0 0

/* flist.f */
verilog/lvda_pkg.sv
verilog/pio_src_if.sv
verilog/input_filter.sv
verilog/discrete_sampler.sv
verilog/interrupt_latch.sv
verilog/pio_controller.sv
verilog/lvda_top.sv
bench/lvda_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lvda_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
